/* hdl/batchPkg.sv */
`default_nettype none

package batchPkg;

    // Code and state widths
    localparam int CODE_W = 3;
    localparam int STATE_W = 16;
    localparam int FRAC = 14;

    typedef logic [CODE_W-1:0] codeType;
    typedef logic signed [STATE_W-1:0] stateType;

    // Pole coefficients with FRAC fractional bits
    localparam stateType LAMBDA_F = 16'sd14336;  // 0.875
    localparam stateType LAMBDA_B = 16'sd12288;  // 0.75

    // Input contribution per code, odd symmetric levels
    localparam stateType LUT_F [0:(1<<CODE_W)-1] = '{
        -16'sd1792, -16'sd1280, -16'sd768, -16'sd256,
        16'sd256, 16'sd768, 16'sd1280, 16'sd1792
    };
    localparam stateType LUT_B [0:(1<<CODE_W)-1] = '{
        -16'sd1050, -16'sd750, -16'sd450, -16'sd150,
        16'sd150, 16'sd450, 16'sd750, 16'sd1050
    };

    // Start-up sequence of the batch controller
    typedef enum logic [1:0] {
        FILL_A,
        FILL_B,
        PRIME,
        RUN
    } ctrlState;

    // Role of each sample bank during one batch
    typedef struct packed {
        logic [1:0] writeBank;
        logic [1:0] lookBank;
        logic [1:0] procBank;
    } bankRoles;

endpackage

`default_nettype wire

/* hdl/batchCounter.sv */
`timescale 1ns/1ps
`default_nettype none

module batchCounter #(
    parameter int DEPTH = 8
) (
    input wire clk,
    input wire rst,
    output logic [$clog2(DEPTH)-1:0] idx,
    output logic batchEnd
);

    localparam int IDX_W = $clog2(DEPTH);
    localparam logic [IDX_W-1:0] LAST = IDX_W'(DEPTH - 1);

    // Wraps on its own since DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (!rst) begin
            idx <= '0;
        end else begin
            idx <= idx + 1'b1;
        end
    end

    // High for the last sample of every batch
    assign batchEnd = (idx == LAST);

endmodule

`default_nettype wire

/* hdl/batchControl.sv */
`timescale 1ns/1ps
`default_nettype none

module batchControl #(
    parameter int DEPTH = 8
) (
    input wire clk,
    input wire rst,
    input wire batchEnd,
    input wire [$clog2(DEPTH)-1:0] idx,
    output batchPkg::bankRoles roles,
    output logic loadInit,
    output logic parity,
    output logic outValid
);

    localparam int IDX_W = $clog2(DEPTH);
    // First aligned sample sits in the combiner output two cycles into RUN
    localparam int ALIGN = 2;

    batchPkg::ctrlState state;
    batchPkg::ctrlState stateNext;

    always_comb begin
        stateNext = state;
        case (state)
            batchPkg::FILL_A: stateNext = batchPkg::FILL_B;
            batchPkg::FILL_B: stateNext = batchPkg::PRIME;
            default: stateNext = batchPkg::RUN;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= batchPkg::FILL_A;
            roles <= '{writeBank: 2'd0, lookBank: 2'd2, procBank: 2'd1};
            parity <= 1'b0;
            outValid <= 1'b0;
        end else begin
            if (batchEnd) begin
                state <= stateNext;
                // Freshly written batch becomes the lookahead batch
                roles.lookBank <= roles.writeBank;
                roles.procBank <= roles.lookBank;
                roles.writeBank <= roles.procBank;
                parity <= ~parity;
            end
            // Sticky until reset
            if (state == batchPkg::RUN && idx == IDX_W'(ALIGN)) begin
                outValid <= 1'b1;
            end
        end
    end

    // Batch start for the lookahead and backward passes
    assign loadInit = (idx == '0);

endmodule

`default_nettype wire

/* hdl/sampleBanks.sv */
`timescale 1ns/1ps
`default_nettype none

module sampleBanks #(
    parameter int DEPTH = 8
) (
    input wire clk,
    input wire batchPkg::codeType in,
    input wire [$clog2(DEPTH)-1:0] idx,
    input wire batchPkg::bankRoles roles,
    output batchPkg::codeType lookCode,
    output batchPkg::codeType backCode,
    output batchPkg::codeType fwdCode
);

    localparam int IDX_W = $clog2(DEPTH);
    localparam int BANKS = 3;

    batchPkg::codeType mem [BANKS][DEPTH];
    logic [IDX_W-1:0] revIdx;

    // Reverse address for the lookahead and backward passes
    assign revIdx = IDX_W'(DEPTH - 1) - idx;

    for (genvar b = 0; b < BANKS; b++) begin : gBank
        always_ff @(posedge clk) begin
            if (roles.writeBank == 2'(b)) begin
                mem[b][idx] <= in;
            end
        end
    end

    // All reads registered, one cycle latency
    always_ff @(posedge clk) begin
        lookCode <= mem[roles.lookBank][revIdx];
        backCode <= mem[roles.procBank][revIdx];
        fwdCode <= mem[roles.procBank][idx];
    end

endmodule

`default_nettype wire

/* hdl/recursionUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module recursionUnit #(
    parameter batchPkg::stateType LAMBDA = batchPkg::LAMBDA_B,
    parameter bit FORWARD = 1'b0
) (
    input wire clk,
    input wire rst,
    input wire batchPkg::codeType code,
    input wire load,
    input wire batchPkg::stateType initVal,
    output batchPkg::stateType state
);

    logic loadQ;
    batchPkg::stateType base;
    batchPkg::stateType scaled;
    batchPkg::stateType contrib;
    logic signed [2*batchPkg::STATE_W-1:0] prod;

    // Code trails the batch start by the bank read latency
    always_ff @(posedge clk) begin
        if (!rst) begin
            loadQ <= 1'b0;
        end else begin
            loadQ <= load;
        end
    end

    assign base = loadQ ? initVal : state;
    assign prod = base * LAMBDA;
    // Same bits as an arithmetic shift by FRAC, truncated with wrap
    assign scaled = prod[batchPkg::FRAC +: batchPkg::STATE_W];
    assign contrib = FORWARD ? batchPkg::LUT_F[code] : batchPkg::LUT_B[code];

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= '0;
        end else begin
            state <= scaled + contrib;
        end
    end

endmodule

`default_nettype wire

/* hdl/resultCombiner.sv */
`timescale 1ns/1ps
`default_nettype none

module resultCombiner #(
    parameter int DEPTH = 8
) (
    input wire clk,
    input wire rst,
    input wire [$clog2(DEPTH)-1:0] idx,
    input wire parity,
    input wire batchPkg::stateType backState,
    input wire batchPkg::stateType fwdState,
    output batchPkg::stateType out
);

    localparam int IDX_W = $clog2(DEPTH);
    // States arrive two cycles behind the counter
    localparam int LAG = 2;

    batchPkg::stateType backMem [2*DEPTH];
    batchPkg::stateType fwdMem [2*DEPTH];
    logic [LAG-1:0] parityDly;
    logic writeHalf;
    logic [IDX_W-1:0] fwdAddr;
    logic [IDX_W-1:0] backAddr;

    // Half switch follows the states, not the counter
    always_ff @(posedge clk) begin
        if (!rst) begin
            parityDly <= '0;
        end else begin
            parityDly <= {parityDly[LAG-2:0], parity};
        end
    end

    assign writeHalf = parityDly[LAG-1];
    assign fwdAddr = idx - IDX_W'(LAG);
    // Backward pass runs in reverse, so its address counts down
    assign backAddr = IDX_W'(LAG - 1) - idx;

    always_ff @(posedge clk) begin
        fwdMem[{writeHalf, fwdAddr}] <= fwdState;
        backMem[{writeHalf, backAddr}] <= backState;
        // Previous batch comes back out in sample order
        out <= fwdMem[{~writeHalf, fwdAddr}] + backMem[{~writeHalf, fwdAddr}];
    end

endmodule

`default_nettype wire

/* hdl/batchFilterTop.sv */
`timescale 1ns/1ps
`default_nettype none

module batchFilterTop #(
    parameter int DEPTH = 8
) (
    input wire clk,
    input wire rst,
    input wire batchPkg::codeType in,
    output batchPkg::stateType out,
    output logic outValid
);

    localparam int IDX_W = $clog2(DEPTH);

    logic [IDX_W-1:0] idx;
    logic batchEnd;
    logic loadInit;
    logic parity;
    logic fwdLoad;
    batchPkg::bankRoles roles;
    batchPkg::codeType lookCode;
    batchPkg::codeType backCode;
    batchPkg::codeType fwdCode;
    batchPkg::stateType lookState;
    batchPkg::stateType backState;
    batchPkg::stateType fwdState;

    batchCounter #(.DEPTH(DEPTH)) counter0 (
        .clk(clk), .rst(rst), .idx(idx), .batchEnd(batchEnd)
    );

    batchControl #(.DEPTH(DEPTH)) control0 (
        .clk(clk), .rst(rst), .batchEnd(batchEnd), .idx(idx),
        .roles(roles), .loadInit(loadInit), .parity(parity), .outValid(outValid)
    );

    sampleBanks #(.DEPTH(DEPTH)) banks0 (
        .clk(clk), .in(in), .idx(idx), .roles(roles),
        .lookCode(lookCode), .backCode(backCode), .fwdCode(fwdCode)
    );

    // Lookahead restarts from zero on every batch
    recursionUnit #(.LAMBDA(batchPkg::LAMBDA_B), .FORWARD(1'b0)) lookUnit (
        .clk(clk), .rst(rst), .code(lookCode), .load(loadInit),
        .initVal('0), .state(lookState)
    );

    // Seeded with the lookahead state that has just finished
    recursionUnit #(.LAMBDA(batchPkg::LAMBDA_B), .FORWARD(1'b0)) backUnit (
        .clk(clk), .rst(rst), .code(backCode), .load(loadInit),
        .initVal(lookState), .state(backState)
    );

    // Forward pass starts from zero on the PRIME batch, the second even batch
    // before outValid, and then runs on without a break
    assign fwdLoad = loadInit & ~outValid & ~parity;

    recursionUnit #(.LAMBDA(batchPkg::LAMBDA_F), .FORWARD(1'b1)) fwdUnit (
        .clk(clk), .rst(rst), .code(fwdCode), .load(fwdLoad),
        .initVal('0), .state(fwdState)
    );

    resultCombiner #(.DEPTH(DEPTH)) combiner0 (
        .clk(clk), .rst(rst), .idx(idx), .parity(parity),
        .backState(backState), .fwdState(fwdState), .out(out)
    );

endmodule

`default_nettype wire

/* sim/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int HALF_PERIOD = 2,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Released on a falling edge so the first active edge is clean
    initial begin
        rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
    end

endmodule

`default_nettype wire

/* sim/batchFilter_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module batchFilter_checker #(
    parameter int DEPTH = 8
) (
    input wire clk,
    input wire rst,
    input wire batchEnd,
    input wire [$clog2(DEPTH)-1:0] idx,
    input wire batchPkg::bankRoles roles,
    input wire loadInit,
    input wire outValid
);

    int assertFails = 0;

    // Only a reset may clear outValid
    validHeld: assert property (@(posedge clk) (rst && $past(rst) && $past(outValid)) |-> outValid)
        else begin
            assertFails++;
            $error("outValid fell without a reset");
        end

    banksDistinct: assert property (@(posedge clk) disable iff (!rst)
        (roles.writeBank != roles.lookBank) && (roles.writeBank != roles.procBank)
        && (roles.lookBank != roles.procBank))
        else begin
            assertFails++;
            $error("two bank roles share one bank");
        end

    // Batch start comes right after a batch end or a reset, and only then
    loadAtBatchStart: assert property (@(posedge clk) disable iff (!rst)
        loadInit == ($past(batchEnd) || !$past(rst)))
        else begin
            assertFails++;
            $error("loadInit out of step with the batch boundary");
        end

    // Freshly written bank becomes the lookahead bank
    rotateAtBatchEnd: assert property (@(posedge clk) disable iff (!rst)
        batchEnd |=> roles.lookBank == $past(roles.writeBank))
        else begin
            assertFails++;
            $error("bank roles did not rotate at batch end");
        end

endmodule

bind batchControl batchFilter_checker #(.DEPTH(DEPTH)) assertions0 (
    .clk(clk), .rst(rst), .batchEnd(batchEnd), .idx(idx), .roles(roles),
    .loadInit(loadInit), .outValid(outValid)
);

`default_nettype wire

/* sim/batchFilterTb.sv */
`timescale 1ns/1ps
`default_nettype none

module batchFilterTb;

    localparam int DEPTH = 8;
    localparam int LATENCY = 3 * DEPTH + 2;
    localparam int HOLD_BATCHES = 15;
    localparam int RANDOM_BATCHES = 40;
    localparam int BG_BATCHES = 10;
    localparam int TAIL_BATCHES = 3;
    localparam int RESTART_BATCHES = 8;
    localparam int RESET_CYCLES = 4;
    localparam int IMPULSE_POS = 5;
    localparam int MAX_SAMPLES = 1024;
    localparam int TOTAL_CYCLES = 2 * RESET_CYCLES + 3 * LATENCY + 2 + DEPTH
        * (HOLD_BATCHES + RANDOM_BATCHES + BG_BATCHES + 1 + TAIL_BATCHES + RESTART_BATCHES);
    localparam int TIMEOUT = TOTAL_CYCLES + 3 * DEPTH + 20;
    localparam batchPkg::codeType HOLD_CODE = 3'd4;
    localparam batchPkg::codeType BG_CODE = 3'd3;
    localparam batchPkg::codeType IMPULSE_CODE = 3'd7;

    logic clk;
    logic porRst;
    logic tbRst;
    logic rst;
    logic outValid;
    batchPkg::codeType codeIn;
    batchPkg::stateType out;

    batchPkg::codeType codeMem [MAX_SAMPLES];
    batchPkg::stateType fwdExp [MAX_SAMPLES];
    batchPkg::stateType expOut [MAX_SAMPLES];
    batchPkg::stateType fwdRun;
    int edgeNum;
    int errorCount;
    int checkCount;
    int cycleCount = 0;
    int settleLo;
    int settleHi;
    int beforeSample;
    bit beforeChecked;
    logic [31:0] rng;

    assign rst = porRst & tbRst;

    clockGen #(.HALF_PERIOD(2), .RESET_CYCLES(RESET_CYCLES)) clock0 (.clk(clk), .rst(porRst));

    batchFilterTop #(.DEPTH(DEPTH)) dut0 (
        .clk(clk), .rst(rst), .in(codeIn), .out(out), .outValid(outValid)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic batchPkg::codeType nextCode();
        rng = xorshift32(rng);
        return rng[batchPkg::CODE_W-1:0];
    endfunction

    // Pole times state with FRAC fraction bits, plus the code's contribution, all wrapping
    function automatic batchPkg::stateType poleStep(input batchPkg::stateType lambda,
            input batchPkg::stateType prev, input batchPkg::stateType contrib);
        logic signed [31:0] prod;
        prod = prev * lambda;
        return batchPkg::stateType'(prod >>> batchPkg::FRAC) + contrib;
    endfunction

    // Reverse pass from zero over the batch seeds the backward pass over it
    task automatic modelBatch(input int k);
        batchPkg::stateType acc;
        int j;
        acc = '0;
        for (j = DEPTH - 1; j >= 0; j--) begin
            acc = poleStep(batchPkg::LAMBDA_B, acc, batchPkg::LUT_B[codeMem[k * DEPTH + j]]);
        end
        for (j = DEPTH - 1; j >= 0; j--) begin
            acc = poleStep(batchPkg::LAMBDA_B, acc, batchPkg::LUT_B[codeMem[k * DEPTH + j]]);
            expOut[k * DEPTH + j] = fwdExp[k * DEPTH + j] + acc;
        end
    endtask

    task automatic checkState(input string name, input batchPkg::stateType actual,
            input batchPkg::stateType expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail at %0t: %s expected %0d, actual %0d", $time, name, expected, actual);
        end
    endtask

    task automatic checkBit(input string name, input logic actual, input logic expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("Fail at %0t: %s expected %b, actual %b", $time, name, expected, actual);
        end
    endtask

    // Drive on the falling edge, check what the rising edge produced
    task automatic stepCycle(input batchPkg::codeType code);
        int s;
        codeIn = code;
        @(posedge clk);
        edgeNum++;
        codeMem[edgeNum] = code;
        fwdRun = poleStep(batchPkg::LAMBDA_F, fwdRun, batchPkg::LUT_F[code]);
        fwdExp[edgeNum] = fwdRun;
        if (edgeNum % DEPTH == DEPTH - 1) begin
            modelBatch(edgeNum / DEPTH);
        end
        @(negedge clk);
        s = edgeNum - LATENCY;
        checkBit("outValid", outValid, s >= 0);
        if (s >= 0) begin
            checkState("out", out, expOut[s]);
            if (s >= settleLo && s < settleHi) begin
                checkState("out vs previous batch", out, expOut[s - DEPTH]);
            end
            if (s == beforeSample) begin
                beforeChecked = 1'b1;
                if (out === expOut[s - DEPTH]) begin
                    errorCount++;
                    $display("No backward response ahead of the impulse at %0t", $time);
                end
            end
        end
    endtask

    task automatic awaitValid(input bit randomCodes, input batchPkg::codeType held);
        int lowCycles;
        lowCycles = 0;
        while (outValid !== 1'b1 && lowCycles <= LATENCY + DEPTH) begin
            stepCycle(randomCodes ? nextCode() : held);
            if (outValid !== 1'b1) begin
                lowCycles++;
            end
        end
        if (lowCycles != LATENCY) begin
            errorCount++;
            $display("outValid stayed low %0d cycles instead of %0d", lowCycles, LATENCY);
        end
    endtask

    task automatic reportTest(input string name, input int mark);
        $display("Test %s finished with %0d errors", name, errorCount - mark);
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > TIMEOUT) begin
            $display("Run did not finish within %0d cycles", TIMEOUT);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        int mark;
        int i;
        codeIn = '0;
        tbRst = 1'b1;
        rng = 32'd22;
        fwdRun = '0;
        edgeNum = -1;
        errorCount = 0;
        checkCount = 0;
        settleLo = 0;
        settleHi = 0;
        beforeSample = -1;
        beforeChecked = 1'b0;
        wait (porRst === 1'b1);

        mark = errorCount;
        checkBit("outValid", outValid, 1'b0);
        awaitValid(1'b0, HOLD_CODE);
        reportTest("startupLatency", mark);

        // Batch 10 is fully settled, so it must repeat batch 9
        mark = errorCount;
        settleLo = (HOLD_BATCHES - 5) * DEPTH;
        settleHi = settleLo + DEPTH;
        while (edgeNum < HOLD_BATCHES * DEPTH - 1) begin
            stepCycle(HOLD_CODE);
        end
        settleLo = 0;
        settleHi = 0;
        reportTest("heldCode", mark);

        mark = errorCount;
        repeat (RANDOM_BATCHES * DEPTH) stepCycle(nextCode());
        reportTest("randomStream", mark);

        mark = errorCount;
        beforeSample = edgeNum + BG_BATCHES * DEPTH + IMPULSE_POS;
        for (i = 0; i < (BG_BATCHES + 1 + TAIL_BATCHES) * DEPTH + LATENCY; i++) begin
            stepCycle(i == BG_BATCHES * DEPTH + IMPULSE_POS ? IMPULSE_CODE : BG_CODE);
        end
        if (!beforeChecked) begin
            errorCount++;
            $display("Impulse batch never reached the output");
        end
        beforeSample = -1;
        reportTest("impulse", mark);

        mark = errorCount;
        tbRst = 1'b0;
        @(posedge clk);
        @(negedge clk);
        checkBit("outValid", outValid, 1'b0);
        repeat (RESET_CYCLES - 1) @(negedge clk);
        tbRst = 1'b1;
        edgeNum = -1;
        fwdRun = '0;
        awaitValid(1'b1, '0);
        repeat (RESTART_BATCHES * DEPTH) stepCycle(nextCode());
        reportTest("midRunReset", mark);

        errorCount += dut0.control0.assertions0.assertFails;
        $display("Checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
hdl/batchPkg.sv
hdl/batchCounter.sv
hdl/batchControl.sv
hdl/sampleBanks.sv
hdl/recursionUnit.sv
hdl/resultCombiner.sv
hdl/batchFilterTop.sv
sim/clockGen.sv
sim/batchFilter_checker.sv
sim/batchFilterTb.sv
